//--- Makefile
# Verilator build for the serial link loopback testbench

VERILATOR ?= verilator
TOP       ?= slink_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
SIM       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FLIST))

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# exit status of the simulation is the test result
run: $(SIM)
	./$(SIM)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

//--- bench/slink_tb.sv
// ######################################
// serial link loopback testbench
// table driven with scoreboard and watchdog
// ######################################

`timescale 1ns/1ps

module slink_tb;
  import slink_pkg::*;

  localparam int FifoDepth = 8;
  localparam int ClkPeriod = 40;
  localparam int NumTests  = 9;
  localparam int NumFixed  = 25;

  // stimulus table where random entries pick their own divisor
  string    test_name [NumTests] = '{"single_div2", "single_div5", "single_div32",
                                     "burst_div32", "full_div32", "clamp_div0",
                                     "clamp_div40", "random_a", "random_b"};
  clk_div_t test_div [NumTests] = '{6'd2, 6'd5, 6'd32, 6'd32, 6'd32, 6'd0, 6'd40, 6'd0, 6'd0};
  int       test_len [NumTests] = '{1, 1, 1, 8, 10, 2, 2, 6, 6};
  bit       test_rnd [NumTests] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1};

  // fixed words consumed in table order
  word_t fixed_words [NumFixed] = '{
    32'h1234_5678, 32'hdead_beef, 32'h8000_0001,
    32'h0000_0000, 32'hffff_ffff, 32'h0123_4567, 32'h89ab_cdef,
    32'ha5a5_a5a5, 32'h5a5a_5a5a, 32'hf0f0_0f0f, 32'h1357_9bdf,
    32'hc001_0001, 32'hc002_0002, 32'hc003_0003, 32'hc004_0004, 32'hc005_0005,
    32'hc006_0006, 32'hc007_0007, 32'hc008_0008, 32'hc009_0009, 32'hc00a_000a,
    32'h0f1e_2d3c, 32'h4b5a_6978, 32'h8796_a5b4, 32'hc3d2_e1f0
  };

  logic     clk = 1'b0;
  logic     arst_n;
  logic     push_valid;
  word_t    push_data;
  clk_div_t clk_div;
  logic     fifo_empty;
  logic     fifo_full;
  logic     fwd_clk;
  lane_t    lanes;
  logic     rx_valid;
  word_t    rx_data;

  // FIFO model and scoreboard
  word_t  sb_q [$];
  int     model_count   = 0;
  int     model_left    = 0;
  bit     model_busy    = 1'b0;
  bit     model_pop     = 1'b0;
  bit     model_push_ok = 1'b0;
  int     cyc           = 0;
  int     tog_cnt       = 0;
  int     last_tog_cyc  = 0;
  int     gap           = 0;
  int     rx_total      = 0;
  int     exp_total     = 0;
  int     fix_ofs       = 0;
  int     total_words   = 0;
  logic   fclk_prev     = 1'b0;
  logic   saw_full      = 1'b0;
  integer seed;
  string  cur_name      = "reset";
  longint wd_limit_ns   = 0;
  word_t  exp_w;

  always #(ClkPeriod / 2) clk = ~clk;

  // forwarded clock and lanes loop straight back
  slink_top #(
    .FifoDepth(FifoDepth)
  ) dut0 (
    .clk_i        (clk),
    .arst_n_i     (arst_n),
    .push_valid_i (push_valid),
    .push_data_i  (push_data),
    .clk_div_i    (clk_div),
    .fifo_empty_o (fifo_empty),
    .fifo_full_o  (fifo_full),
    .ddr_rcv_clk_o(fwd_clk),
    .ddr_o        (lanes),
    .ddr_rcv_clk_i(fwd_clk),
    .ddr_i        (lanes),
    .rx_valid_o   (rx_valid),
    .rx_data_o    (rx_data)
  );

  // expected beat spacing in system clocks
  function automatic int beat_spacing(input clk_div_t div);
    if (div < MinClkDiv) begin
      return MinClkDiv;
    end
    if (div > MaxClkDiv) begin
      return MaxClkDiv;
    end
    return int'(div);
  endfunction

  task automatic abort_run();
    $display("Test failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail %s: expected %b, actual %b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_div(input string name, input clk_div_t exp, input clk_div_t act);
    if (act !== exp) begin
      $display("Fail %s: expected %0d, actual %0d", name, exp, act);
      abort_run();
    end
  endtask

  // FIFO occupancy and pop timing updated once per edge
  always @(posedge clk) begin
    cyc = cyc + 1;
    if (arst_n) begin
      model_pop = 1'b0;
      if (!model_busy) begin
        model_pop = (model_count > 0);
      end else begin
        model_left = model_left - 1;
        if (model_left == 0) begin
          model_pop  = (model_count > 0);
          model_busy = model_pop;
        end
      end
      if (model_pop) begin
        model_busy = 1'b1;
        model_left = BeatsPerWord * beat_spacing(clk_div);
      end
      // a full FIFO drops the push even if it pops in the same cycle
      model_push_ok = push_valid && (model_count < FifoDepth);
      if (model_push_ok) begin
        sb_q.push_back(push_data);
      end
      model_count = model_count + int'(model_push_ok) - int'(model_pop);
    end
  end

  // outputs are stable mid cycle
  always @(negedge clk) begin
    if (arst_n) begin
      check_flag({cur_name, " fifo_empty_o"}, model_count == 0, fifo_empty);
      check_flag({cur_name, " fifo_full_o"}, model_count == FifoDepth, fifo_full);
      if (fifo_full) begin
        saw_full = 1'b1;
      end
      if (fwd_clk !== fclk_prev) begin
        // first beat of a word follows the pop, not a spacing
        if (tog_cnt % BeatsPerWord != 0) begin
          gap = cyc - last_tog_cyc;
          if (gap > 63) begin
            gap = 63;
          end
          check_div({cur_name, " beat spacing"}, clk_div_t'(beat_spacing(clk_div)),
                    clk_div_t'(gap));
        end
        tog_cnt      = tog_cnt + 1;
        last_tog_cyc = cyc;
        fclk_prev    = fwd_clk;
      end
      if (rx_valid) begin
        if (sb_q.size() == 0) begin
          $display("%s: word %h arrived while no word was outstanding", cur_name, rx_data);
          abort_run();
        end else begin
          exp_w = sb_q.pop_front();
          check_word({cur_name, " rx_data_o"}, exp_w, rx_data);
          rx_total = rx_total + 1;
        end
      end
    end
  end

  task automatic run_entry(input int t);
    clk_div_t d;
    word_t    w;
    cur_name = test_name[t];
    saw_full = 1'b0;
    if (test_rnd[t]) begin
      d = clk_div_t'(MinClkDiv +
                     int'($unsigned($random(seed)) % (MaxClkDiv - MinClkDiv + 1)));
    end else begin
      d = test_div[t];
    end
    @(posedge clk);
    #2;
    clk_div = d;
    // back to back pushes at one per cycle
    for (int i = 0; i < test_len[t]; i++) begin
      if (test_rnd[t]) begin
        w = $random(seed);
      end else begin
        w       = fixed_words[fix_ofs];
        fix_ofs = fix_ofs + 1;
      end
      push_valid = 1'b1;
      push_data  = w;
      @(posedge clk);
      #2;
    end
    push_valid = 1'b0;
    while (model_busy || sb_q.size() != 0) begin
      @(negedge clk);
    end
    if (test_len[t] > FifoDepth) begin
      check_flag({cur_name, " full seen"}, 1'b1, saw_full);
    end
  endtask

  initial begin
    arst_n     = 1'b0;
    push_valid = 1'b0;
    push_data  = '0;
    clk_div    = clk_div_t'(MinClkDiv);
    seed       = 32'hc78602c7;
    for (int t = 0; t < NumTests; t++) begin
      total_words = total_words + test_len[t] + 1;
      // one word leaves for the serializer while a burst is pushed
      exp_total = exp_total + ((test_len[t] > FifoDepth + 1) ? FifoDepth + 1 : test_len[t]);
    end
    wd_limit_ns = longint'(total_words * BeatsPerWord * MaxClkDiv + 500) * ClkPeriod;
    repeat (8) @(posedge clk);
    #2;
    arst_n = 1'b1;
    @(negedge clk);
    check_flag("reset fifo_empty_o", 1'b1, fifo_empty);
    check_flag("reset fifo_full_o", 1'b0, fifo_full);
    check_flag("reset rx_valid_o", 1'b0, rx_valid);
    check_flag("reset ddr_rcv_clk_o", 1'b0, fwd_clk);
    check_word("reset ddr_o", '0, word_t'(lanes));
    for (int t = 0; t < NumTests; t++) begin
      run_entry(t);
    end
    // quiet period catches stray words
    repeat (2 * MaxClkDiv) @(negedge clk);
    if (rx_total != exp_total) begin
      $display("Fail word_count: expected %0d, actual %0d", exp_total, rx_total);
      abort_run();
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

  initial begin
    wait (wd_limit_ns > 0);
    #(wd_limit_ns);
    $display("watchdog expired after %0d ns before all tests finished", wd_limit_ns);
    abort_run();
  end

endmodule

//--- design/slink_pkg.sv
// ######################################
// serial link shared definitions
// widths, types and serializer states
// ######################################

package slink_pkg;

  // link geometry, one channel
  localparam int DataWidth    = 32;
  localparam int NumLanes     = 4;
  localparam int BeatsPerWord = DataWidth / NumLanes;

  // beat spacing limits in system clocks
  localparam int MaxClkDiv = 32;
  localparam int MinClkDiv = 2;

  typedef logic [DataWidth-1:0] word_t;
  typedef logic [NumLanes-1:0]  lane_t;

  // must hold MaxClkDiv itself
  typedef logic [$clog2(MaxClkDiv+1)-1:0] clk_div_t;

  typedef logic [$clog2(BeatsPerWord)-1:0] beat_idx_t;

  typedef enum logic {
    TX_IDLE,
    TX_SEND
  } tx_state_e;

endpackage

//--- design/slink_rx_deserializer.sv
// ######################################
// serial link receive deserializer
// oversamples clock and lanes, rebuilds
// words on every forwarded clock edge
// ######################################

`timescale 1ns/1ps

module slink_rx_deserializer (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  logic             ddr_rcv_clk_i,
  input  slink_pkg::lane_t ddr_i,
  output logic             rx_valid_o,
  output slink_pkg::word_t rx_data_o
);
  import slink_pkg::*;

  logic      clk_meta_q;
  logic      clk_sync_q;
  logic      clk_prev_q;
  lane_t     lane_meta_q;
  lane_t     lane_sync_q;
  beat_idx_t beat_cnt_q;
  logic      beat_edge;

  // both edges of the forwarded clock carry a beat
  assign beat_edge = clk_sync_q ^ clk_prev_q;

  // clock and lanes see the same two-stage delay
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      clk_meta_q  <= 1'b0;
      clk_sync_q  <= 1'b0;
      clk_prev_q  <= 1'b0;
      lane_meta_q <= '0;
      lane_sync_q <= '0;
    end else begin
      clk_meta_q  <= ddr_rcv_clk_i;
      clk_sync_q  <= clk_meta_q;
      clk_prev_q  <= clk_sync_q;
      lane_meta_q <= ddr_i;
      lane_sync_q <= lane_meta_q;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      beat_cnt_q <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      // counter wraps back to 0 after the last beat
      rx_valid_o <= beat_edge && (beat_cnt_q == beat_idx_t'(BeatsPerWord - 1));
      if (beat_edge) begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
      end
    end
  end

  // first beat is the low nibble, so shift in from the top
  always_ff @(posedge clk_i) begin
    if (beat_edge) begin
      rx_data_o <= {lane_sync_q, rx_data_o[DataWidth-1:NumLanes]};
    end
  end

endmodule

//--- design/slink_top.sv
// ######################################
// serial link top level
// FIFO, serializer and deserializer
// ######################################

`timescale 1ns/1ps

module slink_top #(
  parameter int FifoDepth = 8
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                push_valid_i,
  input  slink_pkg::word_t    push_data_i,
  input  slink_pkg::clk_div_t clk_div_i,
  output logic                fifo_empty_o,
  output logic                fifo_full_o,
  output logic                ddr_rcv_clk_o,
  output slink_pkg::lane_t    ddr_o,
  input  logic                ddr_rcv_clk_i,
  input  slink_pkg::lane_t    ddr_i,
  output logic                rx_valid_o,
  output slink_pkg::word_t    rx_data_o
);
  import slink_pkg::*;

  word_t fifo_rd_data;
  logic  fifo_pop;

  slink_tx_fifo #(
    .FifoDepth(FifoDepth)
  ) tx_fifo_i (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .push_i     (push_valid_i),
    .push_data_i(push_data_i),
    .pop_i      (fifo_pop),
    .rd_data_o  (fifo_rd_data),
    .empty_o    (fifo_empty_o),
    .full_o     (fifo_full_o)
  );

  slink_tx_serializer tx_serializer_i (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .clk_div_i    (clk_div_i),
    .fifo_empty_i (fifo_empty_o),
    .fifo_data_i  (fifo_rd_data),
    .pop_o        (fifo_pop),
    .ddr_rcv_clk_o(ddr_rcv_clk_o),
    .ddr_o        (ddr_o)
  );

  // receive side sees only the pins
  slink_rx_deserializer rx_deserializer_i (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .ddr_rcv_clk_i(ddr_rcv_clk_i),
    .ddr_i        (ddr_i),
    .rx_valid_o   (rx_valid_o),
    .rx_data_o    (rx_data_o)
  );

endmodule

//--- design/slink_tx_fifo.sv
// ######################################
// serial link transmit FIFO
// word buffer with show-ahead head word
// ######################################

`timescale 1ns/1ps

module slink_tx_fifo #(
  parameter int FifoDepth = 8
) (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  logic             push_i,
  input  slink_pkg::word_t push_data_i,
  input  logic             pop_i,
  output slink_pkg::word_t rd_data_o,
  output logic             empty_o,
  output logic             full_o
);
  import slink_pkg::*;

  localparam int PtrWidth = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;

  word_t               mem_q [FifoDepth];
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [PtrWidth:0]   count_q;
  logic                push_ok;

  // pushes into a full buffer are lost
  assign push_ok = push_i && !full_o;

  assign empty_o   = (count_q == '0);
  assign full_o    = (count_q == (PtrWidth+1)'(FifoDepth));
  assign rd_data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push_ok, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

//--- design/slink_tx_serializer.sv
// ######################################
// serial link transmit serializer
// sends words as nibble beats with a
// toggling forwarded clock
// ######################################

`timescale 1ns/1ps

module slink_tx_serializer (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  slink_pkg::clk_div_t clk_div_i,
  input  logic                fifo_empty_i,
  input  slink_pkg::word_t    fifo_data_i,
  output logic                pop_o,
  output logic                ddr_rcv_clk_o,
  output slink_pkg::lane_t    ddr_o
);
  import slink_pkg::*;

  tx_state_e state_q;
  clk_div_t  div_clamped;
  clk_div_t  div_cnt_q;
  beat_idx_t beat_idx_q;
  word_t     shift_q;
  logic      beat_due;
  logic      word_done;
  logic      load_word;

  // keep the beat spacing inside the supported range
  always_comb begin
    if (clk_div_i < clk_div_t'(MinClkDiv)) begin
      div_clamped = clk_div_t'(MinClkDiv);
    end else if (clk_div_i > clk_div_t'(MaxClkDiv)) begin
      div_clamped = clk_div_t'(MaxClkDiv);
    end else begin
      div_clamped = clk_div_i;
    end
  end

  assign beat_due  = (state_q == TX_SEND) && (div_cnt_q == '0);
  assign word_done = beat_due && (beat_idx_q == beat_idx_t'(BeatsPerWord - 1));

  // take a new word when idle or right after the last beat
  assign load_word = !fifo_empty_i && ((state_q == TX_IDLE) || word_done);
  assign pop_o     = load_word;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q       <= TX_IDLE;
      div_cnt_q     <= '0;
      beat_idx_q    <= '0;
      ddr_rcv_clk_o <= 1'b0;
      ddr_o         <= '0;
    end else if (load_word) begin
      // beat 0 goes out with the pop
      state_q       <= TX_SEND;
      beat_idx_q    <= '0;
      div_cnt_q     <= div_clamped - 1'b1;
      ddr_o         <= fifo_data_i[NumLanes-1:0];
      ddr_rcv_clk_o <= ~ddr_rcv_clk_o;
    end else if (word_done) begin
      // lanes and clock hold their last levels
      state_q <= TX_IDLE;
    end else if (beat_due) begin
      beat_idx_q    <= beat_idx_q + 1'b1;
      div_cnt_q     <= div_clamped - 1'b1;
      ddr_o         <= shift_q[NumLanes-1:0];
      ddr_rcv_clk_o <= ~ddr_rcv_clk_o;
    end else if (state_q == TX_SEND) begin
      div_cnt_q <= div_cnt_q - 1'b1;
    end
  end

  // remaining beats, lowest nibble next
  always_ff @(posedge clk_i) begin
    if (load_word) begin
      shift_q <= fifo_data_i >> NumLanes;
    end else if (beat_due) begin
      shift_q <= shift_q >> NumLanes;
    end
  end

endmodule

//--- flist.f
design/slink_pkg.sv
design/slink_tx_fifo.sv
design/slink_tx_serializer.sv
design/slink_rx_deserializer.sv
design/slink_top.sv
bench/slink_tb.sv
